/* logic/rat_pkg.sv */
`default_nettype none

package rat_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////

    localparam int DATA_W    = 8;   // data word
    localparam int INSTR_W   = 18;  // instruction word
    localparam int PC_W      = 10;  // branch address
    localparam int RF_ADDR_W = 5;   // register index

    typedef logic [DATA_W-1:0]    data_t;
    typedef logic [INSTR_W-1:0]   instr_t;
    typedef logic [PC_W-1:0]      pc_t;
    typedef logic [RF_ADDR_W-1:0] rf_addr_t;

    // {opcode hi 5, opcode lo 2}
    // immediate forms carry the immediate in the lo bits, so they sit with lo = 00
    typedef enum logic [6:0] {
        OP_AND_R  = 7'b00000_00,
        OP_OR_R   = 7'b00000_01,
        OP_EXOR_R = 7'b00000_10,
        OP_ADD_R  = 7'b00001_00,
        OP_SUB_R  = 7'b00001_10,
        OP_CMP_R  = 7'b00010_00,
        OP_MOV_R  = 7'b00010_01,
        OP_BRN    = 7'b00100_00,
        OP_BREQ   = 7'b00100_10,
        OP_BRNE   = 7'b00100_11,
        OP_AND_I  = 7'b10000_00,
        OP_OR_I   = 7'b10001_00,
        OP_EXOR_I = 7'b10010_00,
        OP_ADD_I  = 7'b10100_00,
        OP_SUB_I  = 7'b10110_00,
        OP_CMP_I  = 7'b11000_00,
        OP_IN     = 7'b11001_00,
        OP_OUT    = 7'b11010_00,
        OP_MOV_I  = 7'b11011_00,
        OP_NOP    = 7'b11111_00     // also what any unknown code becomes
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_EXOR,
        ALU_PASSB   // mov
    } alu_op_t;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_ALWAYS,
        BR_IF_Z,
        BR_IF_NZ
    } branch_t;

    typedef enum logic {
        WR_ALU,
        WR_IN_PORT
    } wr_src_t;

    ////////////////////////////////////////////////////////////
    // stage payloads
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        alu_op_t alu_op;
        logic    use_imm;   // b operand from immediate
        logic    rf_wr;
        wr_src_t wr_src;
        logic    z_ld;
        logic    io_strb;
        branch_t branch;
    } ctrl_t;

    typedef struct packed {
        instr_t instr;
        pc_t    pc;         // address the word was read from
    } fetch_pl_t;

    typedef struct packed {
        ctrl_t    ctrl;
        data_t    dx;
        data_t    dy;
        data_t    imm;      // also the port id of in/out
        rf_addr_t wr_addr;
        pc_t      target;
    } exec_pl_t;

endpackage

`default_nettype wire

/* logic/pipe_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     CLK,
    input  logic     rst_n,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
            out_valid <= 1'b0;
        else
            out_valid <= in_valid && !flush;    // flushed slot turns to a bubble
    end

    always_ff @(posedge CLK)
    begin
        out_data <= in_data;
    end

endmodule

`default_nettype wire

/* logic/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic              CLK,
    input  rat_pkg::rf_addr_t rd_addr_x,
    input  rat_pkg::rf_addr_t rd_addr_y,
    input  logic              wr_en,
    input  rat_pkg::rf_addr_t wr_addr,
    input  rat_pkg::data_t    wr_data,
    output rat_pkg::data_t    rd_data_x,
    output rat_pkg::data_t    rd_data_y
);

    localparam int NUM_REGS = 2 ** rat_pkg::RF_ADDR_W;

    rat_pkg::data_t regs [NUM_REGS];

    // write lands at the end of the execute cycle
    always_ff @(posedge CLK)
    begin
        if (wr_en)
            regs[wr_addr] <= wr_data;
    end

    assign rd_data_x = regs[rd_addr_x];     // async reads for decode
    assign rd_data_y = regs[rd_addr_y];

endmodule

`default_nettype wire

/* logic/prog_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module prog_fetch #(
    parameter int ROM_ADDR_W = 10
) (
    input  logic                  CLK,
    input  logic                  rst_n,
    input  logic                  prog_we,
    input  logic [ROM_ADDR_W-1:0] prog_addr,
    input  rat_pkg::instr_t       prog_data,
    input  logic                  redirect,
    input  rat_pkg::pc_t          redirect_pc,
    output rat_pkg::fetch_pl_t    fetch_out,
    output logic                  fetch_valid
);

    localparam int ROM_DEPTH = 2 ** ROM_ADDR_W;

    rat_pkg::instr_t       rom [ROM_DEPTH];
    logic [ROM_ADDR_W-1:0] pc;          // next address to read
    logic [ROM_ADDR_W-1:0] rd_addr;
    logic [ROM_ADDR_W-1:0] rd_pc;       // address of rd_instr
    rat_pkg::instr_t       rd_instr;

    // a redirect goes straight to the memory address, so the target
    // is read in the same edge that the branch leaves execute
    assign rd_addr = redirect ? redirect_pc[ROM_ADDR_W-1:0] : pc;

    ////////////////////////////////////////////////////////////
    // program counter
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pc          <= '0;
            fetch_valid <= 1'b0;
        end
        else
        begin
            pc          <= rd_addr + ROM_ADDR_W'(1);  // wraps at the top
            fetch_valid <= 1'b1;    // first word is out after one edge
        end
    end

    ////////////////////////////////////////////////////////////
    // program memory, load port and synchronous read
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK)
    begin
        if (prog_we)
            rom[prog_addr] <= prog_data;
        rd_instr <= rom[rd_addr];
        rd_pc    <= rd_addr;
    end

    // the stale word read before a redirect is dropped by the
    // flush of the first stage register
    always_comb
    begin
        fetch_out.instr = rd_instr;
        fetch_out.pc    = rat_pkg::pc_t'(rd_pc);
    end

endmodule

`default_nettype wire

/* logic/instr_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
    input  rat_pkg::fetch_pl_t fetch_in,
    input  logic               fetch_valid,
    output rat_pkg::rf_addr_t  rf_addr_x,
    output rat_pkg::rf_addr_t  rf_addr_y,
    input  rat_pkg::data_t     rf_data_x,
    input  rat_pkg::data_t     rf_data_y,
    input  logic               wb_wr,
    input  rat_pkg::rf_addr_t  wb_addr,
    input  rat_pkg::data_t     wb_data,
    output rat_pkg::exec_pl_t  exec_out,
    output logic               exec_valid
);

    logic             is_imm;
    logic [6:0]       op_key;
    rat_pkg::opcode_t op;
    rat_pkg::ctrl_t   ctrl;
    logic             fwd_x;
    logic             fwd_y;

    ////////////////////////////////////////////////////////////
    // opcode decode
    ////////////////////////////////////////////////////////////

    assign is_imm = fetch_in.instr[17];     // hi opcode 1xxxx has an immediate
    assign op_key = is_imm ? {fetch_in.instr[17:13], 2'b00}
                           : {fetch_in.instr[17:13], fetch_in.instr[1:0]};
    assign op     = fetch_valid ? rat_pkg::opcode_t'(op_key) : rat_pkg::OP_NOP;

    always_comb
    begin
        ctrl         = '0;
        ctrl.alu_op  = rat_pkg::ALU_PASSB;
        ctrl.wr_src  = rat_pkg::WR_ALU;
        ctrl.branch  = rat_pkg::BR_NONE;
        ctrl.use_imm = is_imm;
        case (op)
            rat_pkg::OP_ADD_R, rat_pkg::OP_ADD_I:
            begin
                ctrl.alu_op = rat_pkg::ALU_ADD;
                ctrl.rf_wr  = 1'b1;
                ctrl.z_ld   = 1'b1;
            end
            rat_pkg::OP_SUB_R, rat_pkg::OP_SUB_I:
            begin
                ctrl.alu_op = rat_pkg::ALU_SUB;
                ctrl.rf_wr  = 1'b1;
                ctrl.z_ld   = 1'b1;
            end
            rat_pkg::OP_CMP_R, rat_pkg::OP_CMP_I:
            begin
                ctrl.alu_op = rat_pkg::ALU_SUB;  // sub for flags only
                ctrl.z_ld   = 1'b1;
            end
            rat_pkg::OP_AND_R, rat_pkg::OP_AND_I:
            begin
                ctrl.alu_op = rat_pkg::ALU_AND;
                ctrl.rf_wr  = 1'b1;
                ctrl.z_ld   = 1'b1;
            end
            rat_pkg::OP_OR_R, rat_pkg::OP_OR_I:
            begin
                ctrl.alu_op = rat_pkg::ALU_OR;
                ctrl.rf_wr  = 1'b1;
                ctrl.z_ld   = 1'b1;
            end
            rat_pkg::OP_EXOR_R, rat_pkg::OP_EXOR_I:
            begin
                ctrl.alu_op = rat_pkg::ALU_EXOR;
                ctrl.rf_wr  = 1'b1;
                ctrl.z_ld   = 1'b1;
            end
            rat_pkg::OP_MOV_R, rat_pkg::OP_MOV_I: ctrl.rf_wr = 1'b1;   // flags untouched
            rat_pkg::OP_IN:
            begin
                ctrl.rf_wr  = 1'b1;
                ctrl.wr_src = rat_pkg::WR_IN_PORT;
            end
            rat_pkg::OP_OUT:  ctrl.io_strb = 1'b1;
            rat_pkg::OP_BRN:  ctrl.branch  = rat_pkg::BR_ALWAYS;
            rat_pkg::OP_BREQ: ctrl.branch  = rat_pkg::BR_IF_Z;
            rat_pkg::OP_BRNE: ctrl.branch  = rat_pkg::BR_IF_NZ;
            default: ;      // nop and unknown codes
        endcase
    end

    ////////////////////////////////////////////////////////////
    // operands with the execute result forwarded
    ////////////////////////////////////////////////////////////

    assign rf_addr_x = fetch_in.instr[12:8];
    assign rf_addr_y = fetch_in.instr[7:3];

    // execute writes at the end of this cycle, so the file is one behind
    assign fwd_x = wb_wr && (wb_addr == rf_addr_x);
    assign fwd_y = wb_wr && (wb_addr == rf_addr_y);

    always_comb
    begin
        exec_out.ctrl    = ctrl;
        exec_out.dx      = fwd_x ? wb_data : rf_data_x;
        exec_out.dy      = fwd_y ? wb_data : rf_data_y;
        exec_out.imm     = fetch_in.instr[7:0];
        exec_out.wr_addr = fetch_in.instr[12:8];
        exec_out.target  = fetch_in.instr[12:3];
    end

    assign exec_valid = fetch_valid;

endmodule

`default_nettype wire

/* logic/exec_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input  logic              CLK,
    input  logic              rst_n,
    input  rat_pkg::exec_pl_t exec_in,
    input  logic              exec_valid,
    input  rat_pkg::data_t    in_port,
    output logic              wb_wr,
    output rat_pkg::rf_addr_t wb_addr,
    output rat_pkg::data_t    wb_data,
    output logic              redirect,
    output rat_pkg::pc_t      redirect_pc,
    output rat_pkg::data_t    out_port,
    output rat_pkg::data_t    port_id,
    output logic              io_strb
);

    rat_pkg::data_t alu_b;
    rat_pkg::data_t alu_result;
    logic           z_flag;
    logic           taken;

    ////////////////////////////////////////////////////////////
    // alu
    ////////////////////////////////////////////////////////////

    assign alu_b = exec_in.ctrl.use_imm ? exec_in.imm : exec_in.dy;

    always_comb
    begin
        case (exec_in.ctrl.alu_op)
            rat_pkg::ALU_ADD:  alu_result = exec_in.dx + alu_b;   // mod 256
            rat_pkg::ALU_SUB:  alu_result = exec_in.dx - alu_b;
            rat_pkg::ALU_AND:  alu_result = exec_in.dx & alu_b;
            rat_pkg::ALU_OR:   alu_result = exec_in.dx | alu_b;
            rat_pkg::ALU_EXOR: alu_result = exec_in.dx ^ alu_b;
            default:           alu_result = alu_b;
        endcase
    end

    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
            z_flag <= 1'b0;
        else if (exec_valid && exec_in.ctrl.z_ld)
            z_flag <= (alu_result == '0);
    end

    ////////////////////////////////////////////////////////////
    // write-back and branch
    ////////////////////////////////////////////////////////////

    assign wb_wr   = exec_valid && exec_in.ctrl.rf_wr;
    assign wb_addr = exec_in.wr_addr;
    assign wb_data = (exec_in.ctrl.wr_src == rat_pkg::WR_IN_PORT) ? in_port : alu_result;

    // z here is the value left by the previous instruction
    always_comb
    begin
        case (exec_in.ctrl.branch)
            rat_pkg::BR_ALWAYS: taken = 1'b1;
            rat_pkg::BR_IF_Z:   taken = z_flag;
            rat_pkg::BR_IF_NZ:  taken = !z_flag;
            default:            taken = 1'b0;
        endcase
    end

    assign redirect    = exec_valid && taken;   // also flushes both stages
    assign redirect_pc = exec_in.target;

    ////////////////////////////////////////////////////////////
    // output port one cycle after out executes
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
            io_strb <= 1'b0;
        else
            io_strb <= exec_valid && exec_in.ctrl.io_strb;
    end

    always_ff @(posedge CLK)
    begin
        if (exec_valid && exec_in.ctrl.io_strb)
        begin
            out_port <= exec_in.dx;
            port_id  <= exec_in.imm;
        end
    end

endmodule

`default_nettype wire

/* logic/rat_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rat_core #(
    parameter int ROM_ADDR_W = 10
) (
    input  logic                  CLK,
    input  logic                  rst_n,
    input  logic                  prog_we,
    input  logic [ROM_ADDR_W-1:0] prog_addr,
    input  rat_pkg::instr_t       prog_data,
    input  rat_pkg::data_t        in_port,
    output rat_pkg::data_t        out_port,
    output rat_pkg::data_t        port_id,
    output logic                  io_strb
);

    rat_pkg::fetch_pl_t fetch_pl;       // fetch stage out
    logic               fetch_valid;
    rat_pkg::fetch_pl_t dec_pl;         // decode stage in
    logic               dec_valid;
    rat_pkg::exec_pl_t  dec_out_pl;     // decode stage out
    logic               dec_out_valid;
    rat_pkg::exec_pl_t  ex_pl;          // execute stage in
    logic               ex_valid;

    rat_pkg::rf_addr_t  rf_addr_x;
    rat_pkg::rf_addr_t  rf_addr_y;
    rat_pkg::data_t     rf_data_x;
    rat_pkg::data_t     rf_data_y;

    logic               wb_wr;
    rat_pkg::rf_addr_t  wb_addr;
    rat_pkg::data_t     wb_data;
    logic               redirect;
    rat_pkg::pc_t       redirect_pc;

    ////////////////////////////////////////////////////////////
    // fetch
    ////////////////////////////////////////////////////////////

    prog_fetch #(.ROM_ADDR_W(ROM_ADDR_W)) u_fetch (
        .CLK(CLK), .rst_n(rst_n),
        .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
        .redirect(redirect), .redirect_pc(redirect_pc),
        .fetch_out(fetch_pl), .fetch_valid(fetch_valid)
    );

    pipe_stage #(.payload_t(rat_pkg::fetch_pl_t)) u_fd_stage (
        .CLK(CLK), .rst_n(rst_n), .flush(redirect),
        .in_valid(fetch_valid), .in_data(fetch_pl),
        .out_valid(dec_valid), .out_data(dec_pl)
    );

    ////////////////////////////////////////////////////////////
    // decode and register file
    ////////////////////////////////////////////////////////////

    instr_decode u_decode (
        .fetch_in(dec_pl), .fetch_valid(dec_valid),
        .rf_addr_x(rf_addr_x), .rf_addr_y(rf_addr_y),
        .rf_data_x(rf_data_x), .rf_data_y(rf_data_y),
        .wb_wr(wb_wr), .wb_addr(wb_addr), .wb_data(wb_data),
        .exec_out(dec_out_pl), .exec_valid(dec_out_valid)
    );

    reg_file u_rf (
        .CLK(CLK),
        .rd_addr_x(rf_addr_x), .rd_addr_y(rf_addr_y),
        .wr_en(wb_wr), .wr_addr(wb_addr), .wr_data(wb_data),
        .rd_data_x(rf_data_x), .rd_data_y(rf_data_y)
    );

    pipe_stage #(.payload_t(rat_pkg::exec_pl_t)) u_dx_stage (
        .CLK(CLK), .rst_n(rst_n), .flush(redirect),
        .in_valid(dec_out_valid), .in_data(dec_out_pl),
        .out_valid(ex_valid), .out_data(ex_pl)
    );

    ////////////////////////////////////////////////////////////
    // execute and write-back
    ////////////////////////////////////////////////////////////

    exec_unit u_exec (
        .CLK(CLK), .rst_n(rst_n),
        .exec_in(ex_pl), .exec_valid(ex_valid), .in_port(in_port),
        .wb_wr(wb_wr), .wb_addr(wb_addr), .wb_data(wb_data),
        .redirect(redirect), .redirect_pc(redirect_pc),
        .out_port(out_port), .port_id(port_id), .io_strb(io_strb)
    );

endmodule

`default_nettype wire

/* verification/rat_core_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module rat_core_assertions (
    input logic CLK,
    input logic rst_n,
    input logic io_strb,
    input logic out_dec     // an out instruction leaving decode
);

    int failures = 0;

    strb_low_in_reset: assert property (@(posedge CLK) !rst_n |-> !io_strb)
    else
    begin
        failures++;
        $error("io_strb high while rst_n is low");
    end

    strb_known: assert property (@(posedge CLK) disable iff (!rst_n) !$isunknown(io_strb))
    else
    begin
        failures++;
        $error("io_strb unknown after reset");
    end

    // a second cycle only when another out follows straight on
    strb_one_cycle: assert property (@(posedge CLK) disable iff (!rst_n)
                                     !out_dec ##1 io_strb |=> !io_strb)
    else
    begin
        failures++;
        $error("io_strb held longer than one cycle");
    end

endmodule

bind rat_core rat_core_assertions u_assert (
    .CLK(CLK),
    .rst_n(rst_n),
    .io_strb(io_strb),
    .out_dec(dec_out_valid && dec_out_pl.ctrl.io_strb)
);

`default_nettype wire

/* verification/rat_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rat_tb;

    localparam int ROM_ADDR_W   = 6;    // 64 words is plenty for the test programs
    localparam int ROM_DEPTH    = 2 ** ROM_ADDR_W;
    localparam int RESET_CYCLES = 8;
    localparam int RUN_CYCLES   = 40;
    localparam int SETTLE       = 6;    // room for a surplus strobe to show up
    localparam int NUM_TESTS    = 6;
    localparam int MAX_CYCLES   = NUM_TESTS * (RESET_CYCLES + ROM_DEPTH + RUN_CYCLES);

    logic                  CLK;
    logic                  rst_n;
    logic                  prog_we;
    logic [ROM_ADDR_W-1:0] prog_addr;
    rat_pkg::instr_t       prog_data;
    rat_pkg::data_t        in_port;
    rat_pkg::data_t        out_port;
    rat_pkg::data_t        port_id;
    logic                  io_strb;

    rat_pkg::instr_t prog_q [$];
    logic [15:0]     exp_q [$];         // {port_id, out_port}
    logic [15:0]     got_q [$];
    rat_pkg::data_t  model_regs [32];   // registers are never reset, so they carry over
    int              cycle_count;
    int              errors;
    int              tests_run;

    rat_core #(.ROM_ADDR_W(ROM_ADDR_W)) UUT (
        .CLK(CLK), .rst_n(rst_n),
        .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
        .in_port(in_port), .out_port(out_port), .port_id(port_id), .io_strb(io_strb)
    );

    initial CLK = 1'b0;
    always #50 CLK = ~CLK;

    // strobe monitor samples mid cycle
    always @(negedge CLK)
    begin
        if (io_strb === 1'b1)
            got_q.push_back({port_id, out_port});
    end

    always @(posedge CLK)
    begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("Timeout: run stopped after %0d cycles", cycle_count);
            $display("Errors found");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // instruction encoding
    ////////////////////////////////////////////////////////////

    function automatic rat_pkg::instr_t reg_form(input logic [6:0] op, input int rx,
                                                 input int ry);
        return {op[6:2], 5'(rx), 5'(ry), 1'b0, op[1:0]};
    endfunction

    function automatic rat_pkg::instr_t imm_form(input logic [6:0] op, input int rx,
                                                 input rat_pkg::data_t imm);
        return {op[6:2], 5'(rx), imm};
    endfunction

    function automatic rat_pkg::instr_t branch_form(input logic [6:0] op, input int target);
        return {op[6:2], 10'(target), 1'b0, op[1:0]};
    endfunction

    function automatic rat_pkg::data_t rand_byte();
        return 8'($urandom);
    endfunction

    task automatic emit(input rat_pkg::instr_t w);
        prog_q.push_back(w);
    endtask

    task automatic emit_halt();
        emit(branch_form(rat_pkg::OP_BRN, prog_q.size()));     // branch to itself
    endtask

    task automatic next_cycle();
        @(posedge CLK);
        #1;
    endtask

    ////////////////////////////////////////////////////////////
    // reference model of the plain sequential ISA
    ////////////////////////////////////////////////////////////

    task automatic predict_strobes(input rat_pkg::data_t in_val);
        rat_pkg::instr_t w;
        logic [6:0]      key;
        rat_pkg::data_t  a;
        rat_pkg::data_t  b;
        rat_pkg::data_t  r;
        logic            z;
        int              pc;
        int              next_pc;
        exp_q.delete();
        z  = 1'b0;
        pc = 0;
        for (int step = 0; step < 200; step++)
        begin
            w       = (pc < prog_q.size()) ? prog_q[pc] : imm_form(rat_pkg::OP_NOP, 0, 8'h00);
            key     = w[17] ? {w[17:13], 2'b00} : {w[17:13], w[1:0]};
            a       = model_regs[w[12:8]];
            b       = w[17] ? w[7:0] : model_regs[w[7:3]];
            r       = 8'h00;
            next_pc = (pc + 1) % ROM_DEPTH;
            case (key)
                rat_pkg::OP_ADD_R, rat_pkg::OP_ADD_I:   r = a + b;
                rat_pkg::OP_SUB_R, rat_pkg::OP_SUB_I,
                rat_pkg::OP_CMP_R, rat_pkg::OP_CMP_I:   r = a - b;
                rat_pkg::OP_AND_R, rat_pkg::OP_AND_I:   r = a & b;
                rat_pkg::OP_OR_R, rat_pkg::OP_OR_I:     r = a | b;
                rat_pkg::OP_EXOR_R, rat_pkg::OP_EXOR_I: r = a ^ b;
                rat_pkg::OP_MOV_R, rat_pkg::OP_MOV_I:   model_regs[w[12:8]] = b;
                rat_pkg::OP_IN:   model_regs[w[12:8]] = in_val;
                rat_pkg::OP_OUT:  exp_q.push_back({w[7:0], a});
                rat_pkg::OP_BRN:  next_pc = int'(w[12:3]) % ROM_DEPTH;
                rat_pkg::OP_BREQ: if (z) next_pc = int'(w[12:3]) % ROM_DEPTH;
                rat_pkg::OP_BRNE: if (!z) next_pc = int'(w[12:3]) % ROM_DEPTH;
                default: ;
            endcase
            case (key)
                rat_pkg::OP_CMP_R, rat_pkg::OP_CMP_I:
                    z = (r == 8'h00);   // flags only
                rat_pkg::OP_ADD_R, rat_pkg::OP_ADD_I, rat_pkg::OP_SUB_R, rat_pkg::OP_SUB_I,
                rat_pkg::OP_AND_R, rat_pkg::OP_AND_I, rat_pkg::OP_OR_R, rat_pkg::OP_OR_I,
                rat_pkg::OP_EXOR_R, rat_pkg::OP_EXOR_I:
                begin
                    model_regs[w[12:8]] = r;
                    z = (r == 8'h00);
                end
                default: ;
            endcase
            if (next_pc == pc)
                break;          // halt loop reached
            pc = next_pc;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // load, run and compare one program
    ////////////////////////////////////////////////////////////

    task automatic run_test(input string name, input rat_pkg::data_t in_val, input int hold);
        int fails;
        fails = 0;
        rst_n = 1'b0;
        got_q.delete();
        repeat (RESET_CYCLES) next_cycle();
        for (int i = 0; i < ROM_DEPTH; i++)
        begin
            prog_we   = 1'b1;
            prog_addr = ROM_ADDR_W'(i);
            prog_data = (i < prog_q.size()) ? prog_q[i] : imm_form(rat_pkg::OP_NOP, 0, 8'h00);
            next_cycle();
        end
        prog_we = 1'b0;
        repeat (hold) next_cycle();
        if (got_q.size() != 0)
        begin
            $display("Test %s saw %0d strobes while reset was held", name, got_q.size());
            fails++;
        end
        predict_strobes(in_val);
        in_port = in_val;
        rst_n   = 1'b1;
        while (got_q.size() < exp_q.size())
            next_cycle();
        repeat (SETTLE) next_cycle();
        if (got_q.size() != exp_q.size())
        begin
            $display("Mismatch at %0t ns: io_strb count expected %0d got %0d",
                     $time, exp_q.size(), got_q.size());
            fails++;
        end
        for (int i = 0; i < exp_q.size() && i < got_q.size(); i++)
        begin
            if (got_q[i][15:8] !== exp_q[i][15:8])
            begin
                $display("Mismatch at %0t ns: port_id[%0d] expected %h got %h",
                         $time, i, exp_q[i][15:8], got_q[i][15:8]);
                fails++;
            end
            if (got_q[i][7:0] !== exp_q[i][7:0])
            begin
                $display("Mismatch at %0t ns: out_port[%0d] expected %h got %h",
                         $time, i, exp_q[i][7:0], got_q[i][7:0]);
                fails++;
            end
        end
        $display("test %-16s %0d strobes, %0d errors", name, got_q.size(), fails);
        errors += fails;
        tests_run++;
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////

    task automatic test_alu_ops();
        logic [6:0] ops [5] = '{rat_pkg::OP_ADD_R, rat_pkg::OP_SUB_R, rat_pkg::OP_AND_R,
                                rat_pkg::OP_OR_R, rat_pkg::OP_EXOR_R};
        prog_q.delete();
        emit(imm_form(rat_pkg::OP_MOV_I, 1, rand_byte()));
        emit(imm_form(rat_pkg::OP_MOV_I, 2, rand_byte()));
        for (int k = 0; k < 5; k++)
        begin
            emit(reg_form(rat_pkg::OP_MOV_R, 3 + k, 1));   // copy then op with r2
            emit(reg_form(ops[k], 3 + k, 2));
            emit(imm_form(rat_pkg::OP_OUT, 3 + k, 8'(8'h10 + k)));
        end
        emit(imm_form(rat_pkg::OP_ADD_I, 1, rand_byte()));
        emit(imm_form(rat_pkg::OP_OUT, 1, 8'h18));
        emit(imm_form(rat_pkg::OP_SUB_I, 2, rand_byte()));
        emit(imm_form(rat_pkg::OP_OUT, 2, 8'h19));
        emit_halt();
        run_test("alu_ops", 8'h00, 0);
    endtask

    task automatic test_forward_chain();
        prog_q.delete();
        emit(imm_form(rat_pkg::OP_MOV_I, 7, rand_byte()));
        emit(imm_form(rat_pkg::OP_ADD_I, 7, rand_byte()));
        emit(imm_form(rat_pkg::OP_SUB_I, 7, rand_byte()));
        emit(imm_form(rat_pkg::OP_OUT, 7, 8'h20));
        emit(imm_form(rat_pkg::OP_EXOR_I, 7, rand_byte()));
        emit(imm_form(rat_pkg::OP_AND_I, 7, rand_byte()));
        emit(imm_form(rat_pkg::OP_OR_I, 7, rand_byte()));
        emit(imm_form(rat_pkg::OP_OUT, 7, 8'h21));
        emit(reg_form(rat_pkg::OP_MOV_R, 8, 7));
        emit(reg_form(rat_pkg::OP_ADD_R, 8, 7));
        emit(reg_form(rat_pkg::OP_EXOR_R, 8, 7));
        emit(imm_form(rat_pkg::OP_OUT, 8, 8'h22));
        emit_halt();
        run_test("forward_chain", 8'h00, 0);
    endtask

    task automatic test_in_port();
        prog_q.delete();
        emit(imm_form(rat_pkg::OP_IN, 10, 8'h30));
        emit(imm_form(rat_pkg::OP_OUT, 10, 8'h30));
        emit(imm_form(rat_pkg::OP_ADD_I, 10, rand_byte()));
        emit(imm_form(rat_pkg::OP_OUT, 10, 8'h31));
        emit_halt();
        run_test("in_port", rand_byte(), 0);
    endtask

    task automatic test_branch_always();
        prog_q.delete();
        emit(imm_form(rat_pkg::OP_MOV_I, 11, rand_byte()));
        emit(imm_form(rat_pkg::OP_OUT, 11, 8'h40));
        emit(branch_form(rat_pkg::OP_BRN, prog_q.size() + 3));
        emit(imm_form(rat_pkg::OP_ADD_I, 11, 8'h01));     // flushed so it never writes
        emit(imm_form(rat_pkg::OP_OUT, 11, 8'h41));
        emit(imm_form(rat_pkg::OP_OUT, 11, 8'h42));
        emit_halt();
        run_test("branch_always", 8'h00, 0);
    endtask

    task automatic test_cond_branch();
        rat_pkg::data_t v;
        v = rand_byte();
        prog_q.delete();
        emit(imm_form(rat_pkg::OP_MOV_I, 12, v));
        emit(imm_form(rat_pkg::OP_CMP_I, 12, v));
        emit(branch_form(rat_pkg::OP_BREQ, prog_q.size() + 2));
        emit(imm_form(rat_pkg::OP_OUT, 12, 8'h50));
        emit(imm_form(rat_pkg::OP_OUT, 12, 8'h51));
        emit(imm_form(rat_pkg::OP_CMP_I, 12, v ^ 8'h01));
        emit(branch_form(rat_pkg::OP_BREQ, prog_q.size() + 2));
        emit(imm_form(rat_pkg::OP_OUT, 12, 8'h52));
        emit(imm_form(rat_pkg::OP_OUT, 12, 8'h53));
        emit(branch_form(rat_pkg::OP_BRNE, prog_q.size() + 2));
        emit(imm_form(rat_pkg::OP_OUT, 12, 8'h54));
        emit(imm_form(rat_pkg::OP_MOV_I, 13, v));
        emit(reg_form(rat_pkg::OP_CMP_R, 12, 13));
        emit(branch_form(rat_pkg::OP_BRNE, prog_q.size() + 2));
        emit(imm_form(rat_pkg::OP_OUT, 12, 8'h55));
        emit(imm_form(rat_pkg::OP_OUT, 13, 8'h56));
        emit_halt();
        run_test("cond_branch", 8'h00, 0);
    endtask

    // registers read here were written by the earlier tests
    task automatic test_reset_quiet();
        prog_q.delete();
        emit(imm_form(rat_pkg::OP_OUT, 1, 8'h60));
        emit(imm_form(rat_pkg::OP_OUT, 7, 8'h61));
        emit(imm_form(rat_pkg::OP_OUT, 10, 8'h62));
        emit(imm_form(rat_pkg::OP_OUT, 12, 8'h63));
        emit_halt();
        run_test("reset_quiet", 8'h00, 10);
    endtask

    initial
    begin
        void'($urandom(40258));
        rst_n       = 1'b0;
        prog_we     = 1'b0;
        prog_addr   = '0;
        prog_data   = '0;
        in_port     = '0;
        cycle_count = 0;
        errors      = 0;
        tests_run   = 0;
        foreach (model_regs[i])
            model_regs[i] = 'x;
        next_cycle();
        test_alu_ops();
        test_forward_chain();
        test_in_port();
        test_branch_always();
        test_cond_branch();
        test_reset_quiet();
        errors += UUT.u_assert.failures;
        $display("%0d tests run, %0d errors, %0d assertion failures",
                 tests_run, errors, UUT.u_assert.failures);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
logic/rat_pkg.sv
logic/pipe_stage.sv
logic/reg_file.sv
logic/prog_fetch.sv
logic/instr_decode.sv
logic/exec_unit.sv
logic/rat_core.sv
verification/rat_core_assertions.sv
verification/rat_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the rat_core testbench with Verilator, verdict taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 --top-module rat_tb -f sim.f &&
{ ./obj_dir/Vrat_tb +verilator+error+limit+100 > sim.log 2>&1 || true; } &&
cat sim.log &&
grep -qx "No errors" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
